// ==== logic/accel_pkg.sv ====
package accel_pkg;

  // Bus and packet memory widths
  localparam int io_data_w   = 32;
  localparam int io_addr_w   = 8;
  localparam int pmem_addr_w = 10;
  localparam int len_w       = 10;

  // Table sizes
  localparam int pat_entries = 8;
  localparam int ip_entries  = 8;

  // Descriptor queue holds 2**desc_depth_log2 entries
  localparam int desc_depth_log2 = 2;

  // Register word offsets, decoded from io_addr[4:2]
  typedef enum logic [2:0] {
    reg_ctrl = 3'd0,
    reg_len  = 3'd1,
    reg_addr = 3'd2,
    reg_rule = 3'd3,
    reg_ip   = 3'd4
  } reg_e;

  typedef enum logic [1:0] {
    dma_idle,
    dma_read,
    dma_drain
  } dma_state_e;

  typedef struct packed {
    logic [pmem_addr_w-1:0] addr;
    logic [len_w-1:0]       len;
  } desc_t;

  typedef struct packed {
    logic [io_data_w-1:0] data;
    logic                 valid;
    logic                 last;
  } stream_t;

  // One table write, sel_ip picks the blocklist over the pattern table
  typedef struct packed {
    logic                 en;
    logic                 sel_ip;
    logic [2:0]           index;
    logic [io_data_w-1:0] data;
  } rule_wr_t;

endpackage

// ==== logic/sync_fifo.sv ====
module sync_fifo #(
  parameter int width      = 8,
  parameter int depth_log2 = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [width-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [width-1:0]      mem [2**depth_log2];
  logic [depth_log2-1:0] wr_ptr;
  logic [depth_log2-1:0] rd_ptr;
  logic [depth_log2:0]   count;
  logic                  push;
  logic                  pop;

  // Top bit of the count is set only when every slot is occupied
  assign in_ready  = !count[depth_log2];
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== logic/accel_regs.sv ====
module accel_regs (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    io_en,
  input  logic                                    io_wen,
  input  logic [accel_pkg::io_data_w/8-1:0]       io_strb,
  input  logic [accel_pkg::io_addr_w-1:0]         io_addr,
  input  logic [accel_pkg::io_data_w-1:0]         io_wr_data,
  output logic [accel_pkg::io_data_w-1:0]         io_rd_data,
  output logic                                    io_rd_valid,
  output accel_pkg::desc_t                        desc,
  output logic                                    desc_push,
  output logic                                    match_release,
  output logic                                    dma_stop,
  input  logic                                    fifo_full,
  input  logic                                    dma_busy,
  input  logic                                    match_valid,
  input  logic [$clog2(accel_pkg::pat_entries)-1:0] rule_id,
  output logic [accel_pkg::io_data_w-1:0]         src_ip,
  output logic                                    ip_valid,
  input  logic                                    ip_hit,
  input  logic                                    ip_done
);

  accel_pkg::reg_e                 reg_sel;
  logic                            wr_req;
  logic                            rd_req;
  logic [accel_pkg::len_w-1:0]     len_q;
  logic [accel_pkg::pmem_addr_w-1:0] addr_q;
  logic [accel_pkg::io_data_w-1:0] ip_q;
  logic [accel_pkg::io_data_w-1:0] rd_word;
  logic                            rd_ok;
  logic                            rd_stall;
  logic                            stall_q;

  assign reg_sel = accel_pkg::reg_e'(io_addr[4:2]);
  assign wr_req  = io_en && io_wen;
  assign rd_req  = io_en && !io_wen;

  assign desc = '{addr: addr_q, len: len_q};

  // Network byte order to host order for the blocklist lookup
  assign src_ip = {ip_q[7:0], ip_q[15:8], ip_q[23:16], ip_q[31:24]};

  always_ff @(posedge clk) begin
    if (wr_req) begin
      case (reg_sel)
        accel_pkg::reg_len:  len_q  <= io_wr_data[accel_pkg::len_w-1:0];
        accel_pkg::reg_addr: addr_q <= io_wr_data[accel_pkg::pmem_addr_w-1:0];
        accel_pkg::reg_ip:   ip_q   <= io_wr_data;
        default: ;
      endcase
    end
  end

  // Command pulses last one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_push     <= 1'b0;
      match_release <= 1'b0;
      dma_stop      <= 1'b0;
      ip_valid      <= 1'b0;
    end else begin
      desc_push     <= 1'b0;
      match_release <= 1'b0;
      dma_stop      <= 1'b0;
      ip_valid      <= wr_req && reg_sel == accel_pkg::reg_ip;
      if (wr_req && reg_sel == accel_pkg::reg_ctrl && io_strb[0]) begin
        desc_push     <= io_wr_data[0];
        match_release <= io_wr_data[1];
        dma_stop      <= io_wr_data[2];
      end
    end
  end

  always_comb begin
    rd_word  = '0;
    rd_ok    = 1'b1;
    rd_stall = 1'b0;
    case (reg_sel)
      accel_pkg::reg_ctrl: rd_word[2:0] = {fifo_full, dma_busy, match_valid};
      accel_pkg::reg_len:  rd_word[accel_pkg::len_w-1:0] = len_q;
      accel_pkg::reg_addr: rd_word[accel_pkg::pmem_addr_w-1:0] = addr_q;
      accel_pkg::reg_rule: rd_word[$bits(rule_id)-1:0] = rule_id;
      accel_pkg::reg_ip: begin
        rd_word[1:0] = {ip_done, ip_hit};
        // A lookup started this cycle still shows the old done flag
        rd_ok        = ip_done && !ip_valid;
        rd_stall     = !rd_ok;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_req || stall_q) begin
      io_rd_data <= rd_word;
    end
  end

  // The master keeps io_addr on reg_ip while the reply is stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall_q     <= 1'b0;
    end else if (stall_q) begin
      io_rd_valid <= ip_done;
      stall_q     <= !ip_done;
    end else begin
      io_rd_valid <= rd_req && rd_ok;
      stall_q     <= rd_req && rd_stall;
    end
  end

endmodule

// ==== logic/pkt_rd_dma.sv ====
module pkt_rd_dma (
  input  logic                              clk,
  input  logic                              rst,
  input  accel_pkg::desc_t                  desc,
  input  logic                              desc_valid,
  output logic                              desc_ready,
  input  logic                              stop,
  input  logic                              hold,
  output logic                              busy,
  output logic                              pmem_rd_en,
  output logic [accel_pkg::pmem_addr_w-1:0] pmem_rd_addr,
  input  logic [accel_pkg::io_data_w-1:0]   pmem_rd_data,
  output accel_pkg::stream_t                beat
);

  accel_pkg::dma_state_e             state_q;
  logic [accel_pkg::pmem_addr_w-1:0] addr_q;
  logic [accel_pkg::len_w-1:0]       remain_q;
  logic                              accept;
  logic                              final_rd;
  logic                              valid_q;
  logic                              last_q;

  assign desc_ready   = state_q == accel_pkg::dma_idle && !hold;
  assign accept       = desc_valid && desc_ready;
  assign busy         = state_q != accel_pkg::dma_idle;
  assign pmem_rd_en   = state_q == accel_pkg::dma_read;
  assign pmem_rd_addr = addr_q;

  // A stop turns the read issued this cycle into the final one
  assign final_rd = pmem_rd_en && (remain_q == 1 || stop);

  // Memory data arrives one cycle after the read, flags are delayed to match
  assign beat = '{data: pmem_rd_data, valid: valid_q, last: last_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q   <= desc.addr;
      remain_q <= desc.len;
    end else if (pmem_rd_en) begin
      addr_q   <= addr_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= accel_pkg::dma_idle;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= pmem_rd_en;
      last_q  <= final_rd;
      case (state_q)
        accel_pkg::dma_idle: begin
          // Zero-length descriptors are consumed without a transfer
          if (accept && desc.len != '0) begin
            state_q <= accel_pkg::dma_read;
          end
        end
        accel_pkg::dma_read: begin
          if (final_rd) begin
            state_q <= accel_pkg::dma_drain;
          end
        end
        accel_pkg::dma_drain: begin
          if (last_q) begin
            state_q <= accel_pkg::dma_idle;
          end
        end
        default: state_q <= accel_pkg::dma_idle;
      endcase
    end
  end

endmodule

// ==== logic/pattern_matcher.sv ====
module pattern_matcher (
  input  logic                                      clk,
  input  logic                                      rst,
  input  accel_pkg::rule_wr_t                       rule_wr,
  input  accel_pkg::stream_t                        beat,
  input  logic                                      match_release,
  output logic                                      match_valid,
  output logic [$clog2(accel_pkg::pat_entries)-1:0] rule_id,
  output logic                                      busy
);

  logic [accel_pkg::io_data_w-1:0]           pat_q [accel_pkg::pat_entries];
  logic [accel_pkg::pat_entries-1:0]         pat_ok;
  logic                                      tbl_wr;
  logic                                      hit;
  logic [$clog2(accel_pkg::pat_entries)-1:0] hit_idx;
  logic                                      seen_q;
  logic [$clog2(accel_pkg::pat_entries)-1:0] first_q;

  assign tbl_wr = rule_wr.en && !rule_wr.sel_ip;

  // A held result blocks the next packet until software releases it
  assign busy = match_valid;

  always_ff @(posedge clk) begin
    if (tbl_wr) begin
      pat_q[rule_wr.index] <= rule_wr.data;
    end
  end

  // Scan downward so the lowest matching index is the one kept
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = accel_pkg::pat_entries - 1; i >= 0; i--) begin
      if (pat_ok[i] && pat_q[i] == beat.data) begin
        hit     = 1'b1;
        hit_idx = i[$clog2(accel_pkg::pat_entries)-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat.valid && hit && !seen_q) begin
      first_q <= hit_idx;
    end
    if (beat.valid && beat.last) begin
      rule_id <= seen_q ? first_q : hit_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pat_ok      <= '0;
      seen_q      <= 1'b0;
      match_valid <= 1'b0;
    end else begin
      if (tbl_wr) begin
        pat_ok[rule_wr.index] <= 1'b1;
      end
      if (match_release) begin
        match_valid <= 1'b0;
      end
      if (beat.valid) begin
        if (beat.last) begin
          seen_q      <= 1'b0;
          match_valid <= seen_q || hit;
        end else if (hit) begin
          seen_q <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/ip_match.sv ====
module ip_match (
  input  logic                            clk,
  input  logic                            rst,
  input  accel_pkg::rule_wr_t             rule_wr,
  input  logic [accel_pkg::io_data_w-1:0] ip,
  input  logic                            ip_valid,
  output logic                            hit,
  output logic                            done
);

  logic [accel_pkg::io_data_w-1:0]          ip_tbl [accel_pkg::ip_entries];
  logic [accel_pkg::ip_entries-1:0]         ip_ok;
  logic [$clog2(accel_pkg::ip_entries)-1:0] idx_q;
  logic                                     scan_q;
  logic                                     tbl_wr;

  assign tbl_wr = rule_wr.en && rule_wr.sel_ip;

  always_ff @(posedge clk) begin
    if (tbl_wr) begin
      ip_tbl[rule_wr.index] <= rule_wr.data;
    end
  end

  // One entry per cycle, done and hit hold until the next ip_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      ip_ok  <= '0;
      idx_q  <= '0;
      scan_q <= 1'b0;
      hit    <= 1'b0;
      done   <= 1'b0;
    end else begin
      if (tbl_wr) begin
        ip_ok[rule_wr.index] <= 1'b1;
      end
      if (ip_valid) begin
        idx_q  <= '0;
        scan_q <= 1'b1;
        hit    <= 1'b0;
        done   <= 1'b0;
      end else if (scan_q) begin
        if (ip_ok[idx_q] && ip_tbl[idx_q] == ip) begin
          hit <= 1'b1;
        end
        idx_q <= idx_q + 1'b1;
        if (idx_q == accel_pkg::ip_entries - 1) begin
          scan_q <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/accel_wrap.sv ====
module accel_wrap (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [accel_pkg::io_data_w/8-1:0] io_strb,
  input  logic [accel_pkg::io_addr_w-1:0]   io_addr,
  input  logic [accel_pkg::io_data_w-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_w-1:0]   io_rd_data,
  output logic                              io_rd_valid,
  input  accel_pkg::rule_wr_t               rule_wr,
  output logic                              pmem_rd_en,
  output logic [accel_pkg::pmem_addr_w-1:0] pmem_rd_addr,
  input  logic [accel_pkg::io_data_w-1:0]   pmem_rd_data
);

  accel_pkg::desc_t                          desc_in;
  accel_pkg::desc_t                          desc_out;
  accel_pkg::stream_t                        beat;
  logic                                      desc_push;
  logic                                      desc_in_ready;
  logic                                      desc_valid;
  logic                                      desc_ready;
  logic                                      match_release;
  logic                                      dma_stop;
  logic                                      dma_busy;
  logic                                      match_valid;
  logic                                      match_busy;
  logic [$clog2(accel_pkg::pat_entries)-1:0] rule_id;
  logic [accel_pkg::io_data_w-1:0]           src_ip;
  logic                                      ip_valid;
  logic                                      ip_hit;
  logic                                      ip_done;

  accel_regs regs (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc(desc_in), .desc_push(desc_push), .match_release(match_release),
    .dma_stop(dma_stop), .fifo_full(!desc_in_ready), .dma_busy(dma_busy),
    .match_valid(match_valid), .rule_id(rule_id), .src_ip(src_ip),
    .ip_valid(ip_valid), .ip_hit(ip_hit), .ip_done(ip_done)
  );

  sync_fifo #(
    .width($bits(accel_pkg::desc_t)),
    .depth_log2(accel_pkg::desc_depth_log2)
  ) desc_fifo (
    .clk(clk), .rst(rst),
    .in_data(desc_in), .in_valid(desc_push), .in_ready(desc_in_ready),
    .out_data(desc_out), .out_valid(desc_valid), .out_ready(desc_ready)
  );

  pkt_rd_dma dma (
    .clk(clk), .rst(rst),
    .desc(desc_out), .desc_valid(desc_valid), .desc_ready(desc_ready),
    .stop(dma_stop), .hold(match_busy), .busy(dma_busy),
    .pmem_rd_en(pmem_rd_en), .pmem_rd_addr(pmem_rd_addr),
    .pmem_rd_data(pmem_rd_data), .beat(beat)
  );

  pattern_matcher matcher (
    .clk(clk), .rst(rst), .rule_wr(rule_wr), .beat(beat),
    .match_release(match_release), .match_valid(match_valid),
    .rule_id(rule_id), .busy(match_busy)
  );

  ip_match ip_check (
    .clk(clk), .rst(rst), .rule_wr(rule_wr), .ip(src_ip),
    .ip_valid(ip_valid), .hit(ip_hit), .done(ip_done)
  );

endmodule

// ==== dv/accel_wrap_tb.sv ====
module accel_wrap_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Words moved by all packets, plus a fixed margin per test
  localparam int total_words = 16 + 12 + 10 + 14 + 200 + 4 * 8;
  localparam int num_tests   = 6;
  localparam int cycle_limit = total_words + 200 * num_tests;

  logic                clk;
  logic                rst;
  logic                io_en;
  logic                io_wen;
  logic [3:0]          io_strb;
  logic [7:0]          io_addr;
  logic [31:0]         io_wr_data;
  logic [31:0]         io_rd_data;
  logic                io_rd_valid;
  accel_pkg::rule_wr_t rule_wr;
  logic                pmem_rd_en;
  logic [9:0]          pmem_rd_addr;
  logic [31:0]         pmem_rd_data;

  logic [31:0] pmem [1024];
  logic [31:0] pat_tbl [8];
  logic [7:0]  pat_set;
  logic [31:0] bl_tbl [8];
  logic [7:0]  bl_set;
  logic        rd_en_s;
  logic [9:0]  rd_addr_s;
  logic [9:0]  next_addr;
  int          pkt_starts [$];
  int          reads_issued;
  int          cycles;
  int          errors;
  int          test_errors;
  int          tests_done;

  accel_wrap DUT (.*);

  always #50 clk = ~clk;

  // Read requests are sampled mid cycle and answered one cycle later
  always @(negedge clk) begin
    if (pmem_rd_en) begin
      // A read after an idle cycle opens the next queued packet
      if (!rd_en_s) begin
        if (pkt_starts.size() == 0) begin
          $display("error at %0t: memory read with no packet started", $time);
          errors++;
        end else begin
          next_addr = pkt_starts.pop_front();
        end
      end
      if (pmem_rd_addr !== next_addr) begin
        $display("error at %0t: read address %0h, expected %0h",
                 $time, pmem_rd_addr, next_addr);
        errors++;
      end
      next_addr = next_addr + 1'b1;
      reads_issued++;
    end
    rd_en_s   = pmem_rd_en;
    rd_addr_s = pmem_rd_addr;
  end

  always @(posedge clk) begin
    #1;
    if (rd_en_s) begin
      pmem_rd_data = pmem[rd_addr_s];
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Returns {hit, rule} with the lowest entry matching the first matching word
  function automatic logic [3:0] match_ref(input int addr, input int len);
    for (int i = 0; i < len; i++) begin
      for (int j = 0; j < 8; j++) begin
        if (pat_set[j] && pat_tbl[j] == pmem[addr + i]) begin
          return {1'b1, 3'(j)};
        end
      end
    end
    return 4'b0000;
  endfunction

  function automatic logic ip_ref(input logic [31:0] ip_wr);
    for (int j = 0; j < 8; j++) begin
      if (bl_set[j] && bl_tbl[j] == byte_swap(ip_wr)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic bus_write(input accel_pkg::reg_e r, input logic [31:0] data);
    @(posedge clk);
    #1;
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = 4'hf;
    io_addr    = {3'b000, r, 2'b00};
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // Address stays on the bus until the reply arrives
  task automatic bus_read(input accel_pkg::reg_e r, output logic [31:0] data, output int lat);
    @(posedge clk);
    #1;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = {3'b000, r, 2'b00};
    @(posedge clk);
    #1;
    io_en = 1'b0;
    lat   = 1;
    while (!io_rd_valid && lat < 100) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!io_rd_valid) begin
      $display("Read of register %0d got no reply within 100 cycles", r);
      errors++;
    end
    data = io_rd_data;
  endtask

  task automatic load_rule(input logic to_ip, input int idx, input logic [31:0] data);
    @(posedge clk);
    #1;
    rule_wr = '{en: 1'b1, sel_ip: to_ip, index: 3'(idx), data: data};
    @(posedge clk);
    #1;
    rule_wr.en = 1'b0;
    if (to_ip) begin
      bl_tbl[idx] = data;
      bl_set[idx] = 1'b1;
    end else begin
      pat_tbl[idx] = data;
      pat_set[idx] = 1'b1;
    end
  endtask

  task automatic start_packet(input int addr, input int len);
    bus_write(accel_pkg::reg_addr, addr);
    bus_write(accel_pkg::reg_len, len);
    bus_write(accel_pkg::reg_ctrl, 32'h1);
    pkt_starts.push_back(addr);
  endtask

  // Polls status until the DMA has been seen busy and is idle again
  task automatic wait_idle(input logic was_busy, output logic [31:0] status);
    logic seen;
    logic done;
    int   lat;
    seen = was_busy;
    done = 1'b0;
    while (!done) begin
      bus_read(accel_pkg::reg_ctrl, status, lat);
      if (status[1]) begin
        seen = 1'b1;
      end else if (seen) begin
        done = 1'b1;
      end
    end
  endtask

  task automatic check_match(input int addr, input int len, input logic [31:0] status);
    logic [3:0]  exp;
    logic [31:0] d;
    int          lat;
    exp = match_ref(addr, len);
    if (status[0] !== exp[3]) begin
      $display("error at %0t: match_valid %0b for packet at %0h, expected %0b",
               $time, status[0], addr, exp[3]);
      errors++;
    end
    if (exp[3]) begin
      bus_read(accel_pkg::reg_rule, d, lat);
      if (d[2:0] !== exp[2:0]) begin
        $display("error at %0t: rule id %0d for packet at %0h, expected %0d",
                 $time, d[2:0], addr, exp[2:0]);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("Test %0d %s finished with %0d errors", tests_done, name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] status;
    logic [31:0] ip_wr;
    int          lat;
    int          n;
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr      = '0;
    pmem_rd_data = '0;
    rd_en_s      = 1'b0;
    next_addr    = '0;
    reads_issued = 0;
    cycles       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_done   = 0;
    pat_set      = '0;
    bl_set       = '0;
    d = $urandom(32'h87c2);
    for (int a = 0; a < 1024; a++) begin
      pmem[a] = $urandom();
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    bus_write(accel_pkg::reg_len, 32'h2a5);
    bus_write(accel_pkg::reg_addr, 32'h13c);
    bus_read(accel_pkg::reg_len, d, lat);
    if (d !== 32'h2a5 || lat != 1) begin
      $display("error at %0t: len reads %0h after %0d cycles", $time, d, lat);
      errors++;
    end
    bus_read(accel_pkg::reg_addr, d, lat);
    if (d !== 32'h13c || lat != 1) begin
      $display("error at %0t: addr reads %0h after %0d cycles", $time, d, lat);
      errors++;
    end
    end_test("register readback");

    // Entry 7 repeats entry 3, so a word matching both reports 3
    for (int j = 0; j < 7; j++) begin
      load_rule(1'b0, j, $urandom());
    end
    load_rule(1'b0, 7, pat_tbl[3]);
    pmem['h043] = pat_tbl[5];
    pmem['h047] = pat_tbl[2];
    pmem['h089] = pat_tbl[6];
    pmem['h0c0] = pat_tbl[1];
    pmem['h0c2] = pat_tbl[4];
    pmem['h114] = pat_tbl[7];
    pmem['h1b4] = pat_tbl[0];

    start_packet('h000, 16);
    wait_idle(1'b0, status);
    check_match('h000, 16, status);
    start_packet('h040, 12);
    wait_idle(1'b0, status);
    check_match('h040, 12, status);
    end_test("match result");

    bus_write(accel_pkg::reg_ctrl, 32'h2);
    bus_read(accel_pkg::reg_ctrl, d, lat);
    if (d[0] !== 1'b0) begin
      $display("error at %0t: match_valid still set after release", $time);
      errors++;
    end
    start_packet('h080, 10);
    start_packet('h0c0, 14);
    wait_idle(1'b0, status);
    check_match('h080, 10, status);
    bus_write(accel_pkg::reg_ctrl, 32'h2);
    wait_idle(1'b0, status);
    check_match('h0c0, 14, status);
    bus_write(accel_pkg::reg_ctrl, 32'h2);
    end_test("release and queued descriptors");

    for (int j = 0; j < 4; j++) begin
      load_rule(1'b1, j, $urandom());
    end
    ip_wr = byte_swap(bl_tbl[2]);
    bus_write(accel_pkg::reg_ip, ip_wr);
    bus_read(accel_pkg::reg_ip, d, lat);
    if (lat < 2 || d[1:0] !== {1'b1, ip_ref(ip_wr)}) begin
      $display("error at %0t: listed IP gave status %b after %0d cycles", $time, d[1:0], lat);
      errors++;
    end
    ip_wr = byte_swap(bl_tbl[1] + 32'h1);
    bus_write(accel_pkg::reg_ip, ip_wr);
    bus_read(accel_pkg::reg_ip, d, lat);
    if (lat < 2 || d[1:0] !== {1'b1, ip_ref(ip_wr)}) begin
      $display("error at %0t: other IP gave status %b after %0d cycles", $time, d[1:0], lat);
      errors++;
    end
    end_test("source IP lookup");

    reads_issued = 0;
    start_packet('h100, 200);
    while (reads_issued < 40) begin
      @(posedge clk);
    end
    bus_write(accel_pkg::reg_ctrl, 32'h4);
    wait_idle(1'b1, status);
    n = reads_issued;
    if (n < 40 || n >= 200) begin
      $display("error at %0t: stop left %0d reads issued", $time, n);
      errors++;
    end
    check_match('h100, n, status);
    end_test("stop");

    // The result from the stopped packet is still held, so the DMA waits
    start_packet('h200, 8);
    for (int k = 0; k < 3; k++) begin
      bus_write(accel_pkg::reg_ctrl, 32'h1);
      pkt_starts.push_back('h200);
    end
    bus_read(accel_pkg::reg_ctrl, d, lat);
    if (d[2] !== 1'b1 || d[1] !== 1'b0) begin
      $display("error at %0t: full %b busy %b with four queued", $time, d[2], d[1]);
      errors++;
    end
    reads_issued = 0;
    bus_write(accel_pkg::reg_ctrl, 32'h2);
    while (reads_issued < 32 || d[1] || d[0]) begin
      bus_read(accel_pkg::reg_ctrl, d, lat);
      if (d[0]) begin
        bus_write(accel_pkg::reg_ctrl, 32'h2);
      end
    end
    if (d[2] !== 1'b0 || reads_issued != 32) begin
      $display("error at %0t: full %b after %0d reads", $time, d[2], reads_issued);
      errors++;
    end
    end_test("descriptor FIFO full");

    $display("Tests: %0d, errors: %0d", tests_done, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== accel_wrap.f ====
logic/accel_pkg.sv
logic/sync_fifo.sv
logic/accel_regs.sv
logic/pkt_rd_dma.sv
logic/pattern_matcher.sv
logic/ip_match.sv
logic/accel_wrap.sv
dv/accel_wrap_tb.sv
